/* design/coef_bank.sv */
// Reads return one cycle after the address and a slot reads as loaded only after its first degree write
`timescale 1ns/1ps
`default_nettype none

module coef_bank (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic s_we,
	input  wire logic [coproc_cfg_pkg::s_addr_w-1:0] s_addr,
	input  wire logic [coproc_cfg_pkg::coef_width-1:0] s_wdata,
	input  wire logic deg_we,
	input  wire logic [coproc_cfg_pkg::slot_w-1:0] deg_slot,
	input  wire logic [coproc_cfg_pkg::degree_w-1:0] deg_value,
	input  wire logic [coproc_cfg_pkg::slot_w-1:0] rd_slot,
	input  wire logic [coproc_cfg_pkg::s_addr_w-1:0] rd_addr,
	output logic [coproc_cfg_pkg::coef_width-1:0] s_rdata,
	output logic [coproc_cfg_pkg::degree_w-1:0] deg_rdata,
	output logic slot_loaded
);
	import coproc_cfg_pkg::*;

	// Coefficient memory S, slot A starts at word A*11
	logic [coef_width-1:0] s_mem [s_depth];
	logic [degree_w-1:0] deg_mem [slot_count];
	logic [slot_count-1:0] loaded;

	// Memories and read data carry no reset
	always_ff @(posedge clk)
	begin
		if (s_we)
			s_mem[s_addr] <= s_wdata;
		if (deg_we)
			deg_mem[deg_slot] <= deg_value;
		s_rdata <= s_mem[rd_addr];
		deg_rdata <= deg_mem[rd_slot];
	end

	// The loaded flags mark which slots hold a valid degree
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			loaded <= '0;
			slot_loaded <= 1'b0;
		end
		else
		begin
			if (deg_we)
				loaded[deg_slot] <= 1'b1;
			slot_loaded <= loaded[rd_slot];
		end
	end

endmodule

`default_nettype wire

/* design/coproc_cfg_pkg.sv */
// Sizes are fixed for eight slots of up to eleven 16-bit coefficients and are not checked against each other
`default_nettype none

package coproc_cfg_pkg;

	// One coefficient word as it arrives from the host
	localparam int coef_width = 16;

	// Slot layout of the coefficient memory
	localparam int slot_count = 8;
	localparam int slot_stride = 11;
	localparam int max_degree = 10;
	localparam int s_depth = slot_count * slot_stride;

	// Field widths, sized for the values above
	localparam int slot_w = 3;
	localparam int degree_w = 5;
	localparam int s_addr_w = 7;

endpackage

`default_nettype wire

/* design/coproc_isa_pkg.sv */
// Only the STP and RDC opcodes exist here and status codes are the full 32-bit response word
`default_nettype none

package coproc_isa_pkg;

	// Result and status words both travel at this width
	localparam int resp_w = 32;

	// Command opcodes accepted by the engine
	typedef enum logic [0:0] {
		op_stp = 1'b0,
		op_rdc = 1'b1
	} opcode_t;

	// Status codes returned with every response
	typedef enum logic [resp_w-1:0] {
		st_ok = 32'd0,
		st_bad_degree = 32'd2,
		st_bad_index = 32'd3
	} status_t;

endpackage

`default_nettype wire

/* design/data_buffer.sv */
// Host must hold data credits before sending since a write into a full buffer is dropped
`timescale 1ns/1ps
`default_nettype none

module data_buffer #(
	parameter int data_depth = 16
) (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic data_valid,
	input  wire logic [coproc_cfg_pkg::coef_width-1:0] data_word,
	input  wire logic buf_pop,
	output logic [coproc_cfg_pkg::coef_width-1:0] buf_word,
	output logic [$clog2(data_depth+1)-1:0] buf_count,
	output logic data_credit
);
	import coproc_cfg_pkg::*;

	localparam int ptr_w = $clog2(data_depth);
	localparam int cnt_w = $clog2(data_depth + 1);

	logic [coef_width-1:0] mem [data_depth];
	logic [ptr_w-1:0] head;
	logic [ptr_w-1:0] tail;
	logic wr_ok;
	logic rd_ok;

	// A write is only taken while a slot is free, and a pop only while a word is held
	assign wr_ok = data_valid && (buf_count != cnt_w'(data_depth));
	assign rd_ok = buf_pop && (buf_count != '0);

	// The head entry is visible without a read cycle
	assign buf_word = mem[head];

	always_ff @(posedge clk)
	begin
		if (wr_ok)
			mem[tail] <= data_word;
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			head <= '0;
			tail <= '0;
			buf_count <= '0;
			data_credit <= 1'b0;
		end
		else
		begin
			if (wr_ok)
				tail <= (tail == ptr_w'(data_depth - 1)) ? '0 : tail + 1'b1;
			if (rd_ok)
				head <= (head == ptr_w'(data_depth - 1)) ? '0 : head + 1'b1;
			// Occupancy moves by one at most, both sides on the same edge cancel
			case ({wr_ok, rd_ok})
				2'b10: buf_count <= buf_count + 1'b1;
				2'b01: buf_count <= buf_count - 1'b1;
				default: buf_count <= buf_count;
			endcase
			// Each popped word frees one slot, so one credit goes back a cycle later
			data_credit <= rd_ok;
		end
	end

endmodule

`default_nettype wire

/* design/poly_coproc_top.sv */
// Buffer depths are set here and the host starts with data_depth data credits
`timescale 1ns/1ps
`default_nettype none

module poly_coproc_top #(
	parameter int data_depth = 16,
	parameter int resp_depth = 4,
	parameter int resp_credits = 2
) (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic data_valid,
	input  wire logic [coproc_cfg_pkg::coef_width-1:0] data_word,
	output logic data_credit,
	input  wire logic cmd_valid,
	input  coproc_isa_pkg::opcode_t cmd_op,
	input  wire logic [coproc_cfg_pkg::slot_w-1:0] cmd_a,
	input  wire logic [coproc_cfg_pkg::degree_w-1:0] cmd_n,
	output logic cmd_ready,
	input  wire logic resp_credit,
	output logic resp_valid,
	output logic [coproc_isa_pkg::resp_w-1:0] resp_result,
	output logic [coproc_isa_pkg::resp_w-1:0] resp_status
);
	import coproc_cfg_pkg::*;
	import coproc_isa_pkg::*;

	// Buffer to engine
	logic [$clog2(data_depth+1)-1:0] buf_count;
	logic [coef_width-1:0] buf_word;
	logic buf_pop;

	// Engine to bank
	logic s_we;
	logic [s_addr_w-1:0] s_addr;
	logic [coef_width-1:0] s_wdata;
	logic deg_we;
	logic [slot_w-1:0] deg_slot;
	logic [degree_w-1:0] deg_value;
	logic [slot_w-1:0] rd_slot;
	logic [s_addr_w-1:0] rd_addr;
	logic [coef_width-1:0] s_rdata;
	logic [degree_w-1:0] deg_rdata;
	logic slot_loaded;

	// Engine to queue
	logic resp_space;
	logic resp_push;
	logic [resp_w-1:0] push_result;
	logic [resp_w-1:0] push_status;

	data_buffer #(.data_depth(data_depth)) u_data_buffer (.*);

	coef_bank u_coef_bank (.*);

	stp_engine #(.data_depth(data_depth)) u_stp_engine (.*);

	resp_queue #(.resp_depth(resp_depth), .resp_credits(resp_credits)) u_resp_queue (.*);

endmodule

`default_nettype wire

/* design/resp_queue.sv */
// Host must return one credit per consumed entry and never more than resp_credits in total
`timescale 1ns/1ps
`default_nettype none

module resp_queue #(
	parameter int resp_depth = 4,
	parameter int resp_credits = 2
) (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic resp_push,
	input  wire logic [coproc_isa_pkg::resp_w-1:0] push_result,
	input  wire logic [coproc_isa_pkg::resp_w-1:0] push_status,
	input  wire logic resp_credit,
	output logic resp_space,
	output logic resp_valid,
	output logic [coproc_isa_pkg::resp_w-1:0] resp_result,
	output logic [coproc_isa_pkg::resp_w-1:0] resp_status
);
	import coproc_isa_pkg::*;

	localparam int ptr_w = (resp_depth > 1) ? $clog2(resp_depth) : 1;
	localparam int cnt_w = $clog2(resp_depth + 1);
	localparam int crd_w = $clog2(resp_credits + 1);

	logic [resp_w-1:0] res_mem [resp_depth];
	logic [resp_w-1:0] stat_mem [resp_depth];
	logic [ptr_w-1:0] head;
	logic [ptr_w-1:0] tail;
	logic [cnt_w-1:0] count;
	logic [crd_w-1:0] credits;
	logic push_ok;
	logic send;

	assign resp_space = (count != cnt_w'(resp_depth));
	assign push_ok = resp_push && resp_space;
	// An entry leaves only while the host has room for it
	assign send = (count != '0) && (credits != '0);

	always_ff @(posedge clk)
	begin
		if (push_ok)
		begin
			res_mem[tail] <= push_result;
			stat_mem[tail] <= push_status;
		end
		if (send)
		begin
			resp_result <= res_mem[head];
			resp_status <= stat_mem[head];
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
			credits <= crd_w'(resp_credits);
			resp_valid <= 1'b0;
		end
		else
		begin
			if (push_ok)
				tail <= (tail == ptr_w'(resp_depth - 1)) ? '0 : tail + 1'b1;
			if (send)
				head <= (head == ptr_w'(resp_depth - 1)) ? '0 : head + 1'b1;
			count <= count + cnt_w'(push_ok) - cnt_w'(send);
			credits <= credits + crd_w'(resp_credit) - crd_w'(send);
			resp_valid <= send;
		end
	end

endmodule

`default_nettype wire

/* design/stp_engine.sv */
// One command at a time and STP stalls without timeout while the data buffer is empty
`timescale 1ns/1ps
`default_nettype none

module stp_engine #(
	parameter int data_depth = 16
) (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic cmd_valid,
	input  coproc_isa_pkg::opcode_t cmd_op,
	input  wire logic [coproc_cfg_pkg::slot_w-1:0] cmd_a,
	input  wire logic [coproc_cfg_pkg::degree_w-1:0] cmd_n,
	output logic cmd_ready,
	input  wire logic [$clog2(data_depth+1)-1:0] buf_count,
	input  wire logic [coproc_cfg_pkg::coef_width-1:0] buf_word,
	output logic buf_pop,
	output logic s_we,
	output logic [coproc_cfg_pkg::s_addr_w-1:0] s_addr,
	output logic [coproc_cfg_pkg::coef_width-1:0] s_wdata,
	output logic deg_we,
	output logic [coproc_cfg_pkg::slot_w-1:0] deg_slot,
	output logic [coproc_cfg_pkg::degree_w-1:0] deg_value,
	output logic [coproc_cfg_pkg::slot_w-1:0] rd_slot,
	output logic [coproc_cfg_pkg::s_addr_w-1:0] rd_addr,
	input  wire logic [coproc_cfg_pkg::coef_width-1:0] s_rdata,
	input  wire logic [coproc_cfg_pkg::degree_w-1:0] deg_rdata,
	input  wire logic slot_loaded,
	input  wire logic resp_space,
	output logic resp_push,
	output logic [coproc_isa_pkg::resp_w-1:0] push_result,
	output logic [coproc_isa_pkg::resp_w-1:0] push_status
);
	import coproc_cfg_pkg::*;
	import coproc_isa_pkg::*;

	typedef enum logic [2:0] {idle, check, load, write_degree, read_wait, respond} state_t;

	state_t state;
	opcode_t lat_op;
	logic [slot_w-1:0] lat_a;
	logic [degree_w-1:0] lat_n;
	logic [s_addr_w-1:0] slot_base;
	logic [s_addr_w-1:0] wr_addr;
	logic [degree_w-1:0] idx;
	logic n_bad;
	logic [resp_w-1:0] res_q;
	status_t stat_q;

	assign slot_base = s_addr_w'(lat_a) * s_addr_w'(slot_stride);
	assign n_bad = lat_n > degree_w'(max_degree);

	// Commands are taken only from idle
	assign cmd_ready = (state == idle);

	// In load one word moves per cycle that the buffer has one
	assign buf_pop = (state == load) && (buf_count != '0);
	assign s_we = buf_pop;
	assign s_addr = wr_addr;
	assign s_wdata = buf_word;
	assign deg_we = (state == write_degree);
	assign deg_slot = lat_a;
	assign deg_value = lat_n;

	// Out of range indices read the slot base so the address stays inside S
	assign rd_slot = lat_a;
	assign rd_addr = slot_base + (n_bad ? '0 : s_addr_w'(lat_n));

	assign resp_push = (state == respond) && resp_space;
	assign push_result = res_q;
	assign push_status = stat_q;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			state <= idle;
		else
			case (state)
				idle: if (cmd_valid) state <= check;
				check:
				begin
					if (lat_op == op_rdc)
						state <= read_wait;
					else if (n_bad)
						state <= respond;
					else
						state <= load;
				end
				// The last word is the one at index N
				load: if (buf_pop && idx == lat_n) state <= write_degree;
				write_degree: state <= respond;
				read_wait: state <= respond;
				respond: if (resp_space) state <= idle;
				default: state <= idle;
			endcase
	end

	// Command fields, write pointer and the response being built
	always_ff @(posedge clk)
	begin
		if (state == idle && cmd_valid)
		begin
			lat_op <= cmd_op;
			lat_a <= cmd_a;
			lat_n <= cmd_n;
		end
		if (state == check)
		begin
			wr_addr <= slot_base;
			idx <= '0;
			// A bad degree on STP is reported without touching the buffer
			res_q <= '0;
			stat_q <= st_bad_degree;
		end
		if (buf_pop)
		begin
			wr_addr <= wr_addr + 1'b1;
			idx <= idx + 1'b1;
		end
		if (state == write_degree)
		begin
			res_q <= resp_w'(1);
			stat_q <= st_ok;
		end
		// Bank outputs belong to the address driven during check
		if (state == read_wait)
		begin
			if (!slot_loaded || lat_n > deg_rdata)
			begin
				res_q <= '0;
				stat_q <= st_bad_index;
			end
			else
			begin
				res_q <= resp_w'(s_rdata);
				stat_q <= st_ok;
			end
		end
	end

endmodule

`default_nettype wire

/* filelist.f */
design/coproc_cfg_pkg.sv
design/coproc_isa_pkg.sv
design/data_buffer.sv
design/coef_bank.sv
design/stp_engine.sv
design/resp_queue.sv
design/poly_coproc_top.sv
sim/poly_coproc_asserts.sv
sim/resp_checker.sv
sim/poly_coproc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module poly_coproc_tb -f filelist.f -o poly_sim

status=0
out=$(./obj_dir/poly_sim +verilator+error+limit+1000) || status=$?
echo "$out"

if [ "$status" -eq 0 ] && grep -qF "=== PASS ===" <<< "$out"; then
	exit 0
fi
exit 1

/* sim/poly_cases.txt */
# name op a n cnt gap d0 d1 d2 d3 d4 d5 d6 d7 d8 d9 d10 exp_result exp_status (op 0 STP, 1 RDC)
# cnt data words go out before the command with gap idle cycles between them, hex except cnt and gap
stp_deg0 0 0 00 1 0 1a2b 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00000001 0
stp_deg5 0 1 05 6 0 1001 1002 1003 1004 1005 1006 0000 0000 0000 0000 0000 00000001 0
stp_deg10 0 2 0a 11 0 2000 2001 2002 2003 2004 2005 2006 2007 2008 2009 200a 00000001 0
rdc_s0_i0 1 0 00 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00001a2b 0
rdc_s1_i0 1 1 00 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00001001 0
rdc_s1_i5 1 1 05 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00001006 0
rdc_s2_i0 1 2 00 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00002000 0
rdc_s2_i10 1 2 0a 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000200a 0
stp_bad_deg11 0 3 0b 11 0 3000 3001 3002 3003 3004 3005 3006 3007 3008 3009 300a 00000000 2
stp_after_bad 0 3 0a 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00000001 0
rdc_s3_i0 1 3 00 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00003000 0
rdc_s3_i10 1 3 0a 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000300a 0
stp_bad_deg31 0 4 1f 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00000000 2
rdc_empty_slot 1 5 00 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00000000 3
rdc_above_deg 1 1 06 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00000000 3
rdc_after_bad 1 4 00 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00000000 3
stp_shrink 0 2 02 3 0 4440 4441 4442 0000 0000 0000 0000 0000 0000 0000 0000 00000001 0
rdc_shrunk_i2 1 2 02 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00004442 0
rdc_shrunk_i3 1 2 03 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00000000 3
stp_slow 0 6 04 5 3 5a01 5a02 5a03 5a04 5a05 0000 0000 0000 0000 0000 0000 00000001 0
rdc_slow_i0 1 6 00 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00005a01 0
rdc_slow_i4 1 6 04 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00005a05 0
rdc_burst_s0 1 0 00 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00001a2b 0
rdc_burst_s1 1 1 03 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00001004 0
rdc_burst_s2 1 2 01 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00004441 0
rdc_burst_top 1 7 1f 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00000000 3

/* sim/poly_coproc_asserts.sv */
// Bound into data_buffer and resp_queue and tracks each credit loop from its send and return pulses only
`timescale 1ns/1ps
`default_nettype none

module poly_coproc_asserts #(
	parameter int depth = 4,
	parameter int lvl_w = 3,
	parameter int credit_max = 2
) (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic wr_req,
	input  wire logic [lvl_w-1:0] level,
	input  wire logic sent,
	input  wire logic returned
);

	// Failed assertions, read back by the testbench at the end
	int fail_count = 0;

	// Entries or words sent and not yet paid back by a credit
	int in_flight;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			in_flight <= 0;
		else
			in_flight <= in_flight + int'(sent) - int'(returned);
	end

	// A write must never be offered while every entry is taken
	a_no_full_write: assert property (@(posedge clk) disable iff (!rst)
		wr_req |-> (level != lvl_w'(depth)))
		else
		begin
			$error("write offered while the buffer is full");
			fail_count++;
		end

	// More returns than sends, or more sends than credits, push the count out of range
	a_credit_range: assert property (@(posedge clk) disable iff (!rst)
		(in_flight >= 0) && (in_flight <= credit_max))
		else
		begin
			$error("credit counter left its legal range");
			fail_count++;
		end

	// The sender must still hold a credit on the cycle it sends
	a_valid_with_credit: assert property (@(posedge clk) disable iff (!rst)
		sent |-> (in_flight < credit_max))
		else
		begin
			$error("output valid without a credit held");
			fail_count++;
		end

endmodule

bind data_buffer poly_coproc_asserts #(
	.depth(data_depth),
	.lvl_w($clog2(data_depth + 1)),
	.credit_max(data_depth)
) u_asserts (
	.clk(clk),
	.rst(rst),
	.wr_req(data_valid),
	.level(buf_count),
	.sent(data_valid),
	.returned(data_credit)
);

bind resp_queue poly_coproc_asserts #(
	.depth(resp_depth),
	.lvl_w($clog2(resp_depth + 1)),
	.credit_max(resp_credits)
) u_asserts (
	.clk(clk),
	.rst(rst),
	.wr_req(resp_push),
	.level(count),
	.sent(resp_valid),
	.returned(resp_credit)
);

`default_nettype wire

/* sim/poly_coproc_tb.sv */
// Reads sim/poly_cases.txt from the working directory and holds at most 32 tests
`timescale 1ns/1ps
`default_nettype none

module poly_coproc_tb;
	import coproc_cfg_pkg::*;
	import coproc_isa_pkg::*;

	localparam int data_depth = 16;
	localparam int resp_depth = 4;
	localparam int resp_credits = 2;
	localparam int reset_cycles = 16;
	localparam int cycles_per_test = 60;
	localparam int max_tests = 32;

	logic clk;
	logic rst;
	logic data_valid;
	logic [coef_width-1:0] data_word;
	logic data_credit;
	logic cmd_valid;
	opcode_t cmd_op;
	logic [slot_w-1:0] cmd_a;
	logic [degree_w-1:0] cmd_n;
	logic cmd_ready;
	logic resp_credit;
	logic resp_valid;
	logic [resp_w-1:0] resp_result;
	logic [resp_w-1:0] resp_status;

	// Test table filled from the cases file
	string t_name [max_tests];
	logic t_op [max_tests];
	logic [slot_w-1:0] t_a [max_tests];
	logic [degree_w-1:0] t_n [max_tests];
	int t_cnt [max_tests];
	int t_gap [max_tests];
	logic [coef_width-1:0] t_words [max_tests][11];
	logic [resp_w-1:0] t_result [max_tests];
	logic [resp_w-1:0] t_status [max_tests];
	int n_tests = 0;
	bit file_error = 1'b0;
	bit cases_read = 1'b0;

	int cycle_count = 0;
	int cycle_limit = 0;
	int data_credits;
	int resp_seen = 0;
	int credits_returned = 0;
	integer seed = 9859;

	poly_coproc_top #(
		.data_depth(data_depth),
		.resp_depth(resp_depth),
		.resp_credits(resp_credits)
	) UUT (.*);

	resp_checker u_resp_checker (
		.clk(clk),
		.rst(rst),
		.resp_valid(resp_valid),
		.resp_result(resp_result),
		.resp_status(resp_status)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	// Host side data credits, one spent per word sent and one back per credit pulse
	always @(posedge clk or negedge rst)
	begin
		if (!rst)
			data_credits <= data_depth;
		else
			data_credits <= data_credits + int'(data_credit) - int'(data_valid);
	end

	always @(negedge clk)
	begin
		if (rst && resp_valid)
			resp_seen <= resp_seen + 1;
	end

	task automatic read_cases();
		int fd;
		int got;
		int k;
		string line;
		string nm;
		logic op;
		logic [slot_w-1:0] a;
		logic [degree_w-1:0] n;
		int cnt;
		int gap;
		logic [coef_width-1:0] w [11];
		logic [resp_w-1:0] r;
		logic [resp_w-1:0] s;
		fd = $fopen("sim/poly_cases.txt", "r");
		if (fd == 0)
		begin
			$display("cases file sim/poly_cases.txt could not be opened");
			file_error = 1'b1;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			got = $fgets(line, fd);
			// Comment and blank lines carry no test
			if (got == 0 || line.len() < 2 || line[0] == "#")
				continue;
			got = $sscanf(line, "%s %h %h %h %d %d %h %h %h %h %h %h %h %h %h %h %h %h %h",
				nm, op, a, n, cnt, gap, w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7],
				w[8], w[9], w[10], r, s);
			if (got != 19 || n_tests == max_tests || cnt > 11)
			begin
				$display("cases file line could not be used: %s", line);
				file_error = 1'b1;
				continue;
			end
			t_name[n_tests] = nm;
			t_op[n_tests] = op;
			t_a[n_tests] = a;
			t_n[n_tests] = n;
			t_cnt[n_tests] = cnt;
			t_gap[n_tests] = gap;
			for (k = 0; k < 11; k++)
				t_words[n_tests][k] = w[k];
			t_result[n_tests] = r;
			t_status[n_tests] = s;
			n_tests++;
		end
		$fclose(fd);
	endtask

	// Sends the test's words, waiting whenever the data credits run out
	task automatic send_words(input int idx);
		int k;
		int g;
		for (k = 0; k < t_cnt[idx]; k++)
		begin
			while (data_credits == 0)
			begin
				@(posedge clk);
				#1;
			end
			data_valid = 1'b1;
			data_word = t_words[idx][k];
			@(posedge clk);
			#1;
			data_valid = 1'b0;
			for (g = 0; g < t_gap[idx]; g++)
			begin
				@(posedge clk);
				#1;
			end
		end
	endtask

	// The command transfers on the rising edge after a falling edge that shows cmd_ready
	task automatic send_command(input int idx);
		cmd_valid = 1'b1;
		cmd_op = opcode_t'(t_op[idx]);
		cmd_a = t_a[idx];
		cmd_n = t_n[idx];
		@(negedge clk);
		while (!cmd_ready)
			@(negedge clk);
		@(posedge clk);
		#1;
		cmd_valid = 1'b0;
	endtask

	initial
	begin : main_flow
		int i;
		rst = 1'b0;
		data_valid = 1'b0;
		data_word = '0;
		cmd_valid = 1'b0;
		cmd_op = op_stp;
		cmd_a = '0;
		cmd_n = '0;
		read_cases();
		cycle_limit = cycles_per_test * n_tests + reset_cycles;
		cases_read = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst = 1'b1;
		@(posedge clk);
		#1;
		for (i = 0; i < n_tests; i++)
		begin
			send_words(i);
			u_resp_checker.add_expected(t_name[i], t_result[i], t_status[i]);
			send_command(i);
		end
	end

	// Each consumed response returns one credit after 0 to 3 cycles
	initial
	begin : credit_return
		int wait_cycles;
		int k;
		resp_credit = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			resp_credit = 1'b0;
			if (credits_returned < resp_seen)
			begin
				wait_cycles = $unsigned($random(seed)) % 4;
				for (k = 0; k < wait_cycles; k++)
				begin
					@(posedge clk);
					#1;
				end
				resp_credit = 1'b1;
				credits_returned++;
			end
		end
	end

	initial
	begin : final_report
		bit timed_out;
		int assert_fails;
		int errors;
		wait (cases_read);
		while (u_resp_checker.resp_count < n_tests && cycle_count < cycle_limit)
			@(posedge clk);
		timed_out = (u_resp_checker.resp_count < n_tests);
		if (timed_out)
			$display("no response before cycle limit");
		// A few spare cycles let a stray extra response show up
		repeat (4) @(posedge clk);
		assert_fails = UUT.u_data_buffer.u_asserts.fail_count
			+ UUT.u_resp_queue.u_asserts.fail_count;
		errors = u_resp_checker.fail_count + assert_fails + int'(timed_out) + int'(file_error);
		if (n_tests == 0)
			errors++;
		// Every word sent has been stored by now, so all data credits are back
		if (data_credits != data_depth)
		begin
			$display("data credits not all returned: %0d of %0d held at the end",
				data_credits, data_depth);
			errors++;
		end
		$display("tests %0d responses %0d passed %0d failed %0d assertion failures %0d",
			n_tests, u_resp_checker.resp_count, u_resp_checker.pass_count,
			u_resp_checker.fail_count, assert_fails);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/resp_checker.sv */
// Expected responses must be queued before their command is sent, responses are sampled at the falling edge
`timescale 1ns/1ps
`default_nettype none

module resp_checker (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic resp_valid,
	input  wire logic [coproc_isa_pkg::resp_w-1:0] resp_result,
	input  wire logic [coproc_isa_pkg::resp_w-1:0] resp_status
);
	import coproc_isa_pkg::*;

	// Expected entries in command order
	string exp_name [$];
	logic [resp_w-1:0] exp_result [$];
	logic [resp_w-1:0] exp_status [$];

	int resp_count = 0;
	int pass_count = 0;
	int fail_count = 0;

	task automatic add_expected(input string name, input logic [resp_w-1:0] result,
		input logic [resp_w-1:0] status);
		exp_name.push_back(name);
		exp_result.push_back(result);
		exp_status.push_back(status);
	endtask

	// resp_valid and its data are registered, so mid-cycle they are settled
	always @(negedge clk)
	begin : compare_response
		string name;
		logic [resp_w-1:0] want_result;
		logic [resp_w-1:0] want_status;
		if (rst && resp_valid)
		begin
			if (exp_name.size() == 0)
			begin
				$display("response arrived with no command outstanding: result %08h status %0d",
					resp_result, resp_status);
				fail_count++;
			end
			else
			begin
				name = exp_name.pop_front();
				want_result = exp_result.pop_front();
				want_status = exp_status.pop_front();
				resp_count++;
				if (resp_result === want_result && resp_status === want_status)
				begin
					$display("[OK] %s result %08h status %0d", name, resp_result, resp_status);
					pass_count++;
				end
				else
				begin
					$display("[ERROR] %s expected result %08h status %0d, actual result %08h status %0d",
						name, want_result, want_status, resp_result, resp_status);
					fail_count++;
				end
			end
		end
	end

endmodule

`default_nettype wire
